/* include/pixels_params.svh */
`ifndef PIXELS_PARAMS_SVH
`define PIXELS_PARAMS_SVH

// Output rows per beat
`define ROWS 8

// Largest kernel height, odd
`define KH_MAX 3

// Image limits
`define CI_MAX 8
`define XW_MAX 16
`define XH_MAX 64

// Pixel word width and words per input beat
`define X_BITS 8
`define S_WORDS 4

// One edge entry per column and channel
`define RAM_EDGES_DEPTH 128

// Rows kept above and below each block
`define EDGE_WORDS (`KH_MAX / 2)

`endif

/* rtl/pix_pkg.sv */
`include "pixels_params.svh"

package pix_pkg;

  // One pixel
  typedef logic [`X_BITS-1:0] word_t;

  // Input beat and its keep bits
  typedef logic [`S_WORDS-1:0][`X_BITS-1:0] s_beat_t;
  typedef logic [`S_WORDS-1:0] s_keep_t;

  // Column chunk: block rows then lookahead rows
  typedef logic [`ROWS+`EDGE_WORDS-1:0][`X_BITS-1:0] chunk_t;

  typedef logic [`EDGE_WORDS-1:0][`X_BITS-1:0] edge_t;

  // One output beat
  typedef logic [`ROWS-1:0][`X_BITS-1:0] block_t;

endpackage

/* rtl/cfg_pkg.sv */
`include "pixels_params.svh"

package cfg_pkg;

  // Configuration beat fields, low bits first in this order
  typedef logic [$clog2((`KH_MAX + 1) / 2)-1:0] kh2_t;
  typedef logic [$clog2(`CI_MAX)-1:0] ci_t;
  typedef logic [$clog2(`XW_MAX)-1:0] w_t;
  typedef logic [$clog2(`XH_MAX / `ROWS)-1:0] l_t;

  // Tap index, 0 to 2*kh2
  typedef logic [$clog2(`KH_MAX)-1:0] kh_t;

  typedef logic [$clog2(`RAM_EDGES_DEPTH)-1:0] ram_addr_t;

  // SET takes the configuration beat, PASS forwards pixels,
  // BLOCK drains after the last input beat
  typedef enum logic [1:0] {
    SET,
    PASS,
    BLOCK
  } stream_state_t;

endpackage

/* rtl/loop_counter.sv */
`timescale 1ns/1ps

module loop_counter #(
  parameter int W = 4
) (
  input  logic         aclk,
  input  logic         clear,
  input  logic         en,
  input  logic [W-1:0] max_in,
  output logic         last_clk,
  output logic         last,
  output logic         first
);

  logic [W-1:0] count;
  logic [W-1:0] max_q;

  // Limit is taken together with the clear
  always_ff @(posedge aclk) begin
    if (clear) begin
      count <= '0;
      max_q <= max_in;
    end else if (en) begin
      if (last) begin
        count <= '0;
      end else begin
        count <= count + 1'b1;
      end
    end
  end

  assign first    = (count == '0);
  assign last     = (count == max_q);
  assign last_clk = last && en;

endmodule

/* rtl/edge_ram.sv */
`timescale 1ns/1ps
`include "pixels_params.svh"

module edge_ram (
  input  logic               aclk,
  input  logic               en,
  input  logic               we,
  input  cfg_pkg::ram_addr_t addr,
  input  pix_pkg::edge_t     din,
  output pix_pkg::edge_t     dout
);

  pix_pkg::edge_t mem [`RAM_EDGES_DEPTH];

  // Read-first, so a write returns the previous contents
  always_ff @(posedge aclk) begin
    if (en) begin
      if (we) begin
        mem[addr] <= din;
      end
      dout <= mem[addr];
    end
  end

endmodule

/* rtl/pixel_word_packer.sv */
`timescale 1ns/1ps
`include "pixels_params.svh"

module pixel_word_packer (
  input  logic             aclk,
  input  logic             aresetn,
  input  logic             s_valid,
  input  logic             s_last,
  input  pix_pkg::s_beat_t s_data,
  input  pix_pkg::s_keep_t s_keep,
  output logic             s_ready,
  output logic             m_valid,
  output logic             m_last,
  output pix_pkg::chunk_t  m_data,
  input  logic             m_ready
);

  localparam int CHUNK_WORDS = `ROWS + `EDGE_WORDS;
  localparam int BEAT_WORDS  = `S_WORDS;

  // Room for a chunk minus one word plus a full beat
  localparam int ACC_WORDS   = CHUNK_WORDS + BEAT_WORDS - 1;
  localparam int CNT_W       = $clog2(ACC_WORDS + 1);

  logic [ACC_WORDS-1:0][`X_BITS-1:0] acc;
  logic [CNT_W-1:0] fill;
  logic last_seen;
  logic s_fire;
  logic m_fire;

  // Input waits while a whole chunk sits in the accumulator
  assign s_ready = (fill < CHUNK_WORDS) && !last_seen;
  assign m_valid = (fill >= CHUNK_WORDS);
  assign m_data  = acc[CHUNK_WORDS-1:0];

  // Once last is in, the next chunk out is the final one
  assign m_last  = last_seen;

  assign s_fire  = s_valid && s_ready;
  assign m_fire  = m_valid && m_ready;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      fill      <= '0;
      last_seen <= 1'b0;
    end else if (m_fire) begin
      fill <= fill - CNT_W'(CHUNK_WORDS);
      if (m_last) begin
        last_seen <= 1'b0;
      end
    end else if (s_fire) begin
      fill <= fill + CNT_W'($countones(s_keep));
      if (s_last) begin
        last_seen <= 1'b1;
      end
    end
  end

  // Keep is a run from word 0, so word j lands at fill + j
  always_ff @(posedge aclk) begin
    if (m_fire) begin
      // Leftover words move down to the front
      for (int i = 0; i < ACC_WORDS - CHUNK_WORDS; i++) begin
        acc[i] <= acc[i + CHUNK_WORDS];
      end
    end else if (s_fire) begin
      for (int j = 0; j < BEAT_WORDS; j++) begin
        if (s_keep[j]) begin
          acc[int'(fill) + j] <= s_data[j];
        end
      end
    end
  end

endmodule

/* rtl/axis_pixels.sv */
`timescale 1ns/1ps
`include "pixels_params.svh"

module axis_pixels (
  input  logic             aclk,
  input  logic             aresetn,
  output logic             s_ready,
  input  logic             s_valid,
  input  logic             s_last,
  input  pix_pkg::s_beat_t s_data,
  input  pix_pkg::s_keep_t s_keep,
  input  logic             m_ready,
  output logic             m_valid,
  output pix_pkg::block_t  m_data,
  output logic             m_last
);

  localparam int EDGE_WORDS  = `EDGE_WORDS;
  localparam int SHIFT_WORDS = `ROWS + 2 * EDGE_WORDS;
  localparam int CFG_BITS    = $bits(cfg_pkg::kh2_t) + $bits(cfg_pkg::ci_t) +
                               $bits(cfg_pkg::w_t) + $bits(cfg_pkg::l_t);

  cfg_pkg::stream_state_t state;

  logic [$bits(pix_pkg::s_beat_t)-1:0] s_flat;
  cfg_pkg::kh2_t cfg_kh2;
  cfg_pkg::ci_t  cfg_ci;
  cfg_pkg::w_t   cfg_w;
  cfg_pkg::l_t   cfg_l;
  cfg_pkg::kh2_t kh2_q;

  logic pk_s_valid;
  logic pk_s_ready;
  logic pk_m_valid;
  logic pk_m_ready;
  logic pk_m_last;
  pix_pkg::chunk_t pk_m_data;

  logic en_config;
  logic s_take;
  logic en_copy;
  logic m_beat;
  logic s_last_beat;
  logic m_last_beat;

  logic last_kh;
  logic last_clk_ci;
  logic last_clk_w;
  logic first_l;
  logic last_l;

  cfg_pkg::ram_addr_t ram_addr;
  logic ram_en;
  logic ram_we;
  pix_pkg::edge_t edge_bot;
  pix_pkg::edge_t ram_dout;
  pix_pkg::edge_t edge_top;

  logic r_vld;
  logic r_last;
  logic first_l_r;
  pix_pkg::chunk_t data_r;

  logic [SHIFT_WORDS-1:0][`X_BITS-1:0] shift_reg;
  logic chunk_last;

  // Configuration fields from the low bits of the first beat
  assign s_flat = s_data;
  assign {cfg_l, cfg_w, cfg_ci, cfg_kh2} = s_flat[CFG_BITS-1:0];

  pixel_word_packer u_packer (
    .aclk    (aclk),
    .aresetn (aresetn),
    .s_valid (pk_s_valid),
    .s_last  (s_last),
    .s_data  (s_data),
    .s_keep  (s_keep),
    .s_ready (pk_s_ready),
    .m_valid (pk_m_valid),
    .m_last  (pk_m_last),
    .m_data  (pk_m_data),
    .m_ready (pk_m_ready)
  );

  assign en_config   = (state == cfg_pkg::SET);
  assign m_beat      = m_valid && m_ready;
  assign m_last_beat = m_beat && m_last;
  assign s_last_beat = pk_s_valid && pk_s_ready && s_last;

  // Shift register is free when empty or on its last tap
  assign s_take      = m_ready && (!m_valid || last_kh);
  assign pk_m_ready  = !en_config && s_take;
  assign en_copy     = pk_m_valid && pk_m_ready;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state <= cfg_pkg::SET;
    end else begin
      unique case (state)
        cfg_pkg::SET:   if (s_valid) state <= cfg_pkg::PASS;
        cfg_pkg::PASS:  if (s_last_beat) state <= cfg_pkg::BLOCK;
        cfg_pkg::BLOCK: if (m_last_beat) state <= cfg_pkg::SET;
        default:        state <= cfg_pkg::SET;
      endcase
    end
  end

  always_comb begin
    s_ready    = 1'b0;
    pk_s_valid = 1'b0;
    unique case (state)
      cfg_pkg::SET: begin
        s_ready = 1'b1;
      end
      cfg_pkg::PASS: begin
        s_ready    = pk_s_ready;
        pk_s_valid = s_valid;
      end
      default: begin
        s_ready = 1'b0;
      end
    endcase
  end

  always_ff @(posedge aclk) begin
    if (en_config) begin
      kh2_q <= cfg_kh2;
    end
  end

  // Taps count output beats, the others count accepted chunks
  loop_counter #(.W($bits(cfg_pkg::kh_t))) u_cnt_kh (
    .aclk     (aclk),
    .clear    (en_config),
    .en       (m_beat),
    .max_in   (cfg_pkg::kh_t'({cfg_kh2, 1'b0})),
    .last_clk (),
    .last     (last_kh),
    .first    ()
  );

  loop_counter #(.W($bits(cfg_pkg::ci_t))) u_cnt_ci (
    .aclk     (aclk),
    .clear    (en_config),
    .en       (en_copy),
    .max_in   (cfg_ci),
    .last_clk (last_clk_ci),
    .last     (),
    .first    ()
  );

  loop_counter #(.W($bits(cfg_pkg::w_t))) u_cnt_w (
    .aclk     (aclk),
    .clear    (en_config),
    .en       (last_clk_ci),
    .max_in   (cfg_w),
    .last_clk (last_clk_w),
    .last     (),
    .first    ()
  );

  loop_counter #(.W($bits(cfg_pkg::l_t))) u_cnt_l (
    .aclk     (aclk),
    .clear    (en_config),
    .en       (last_clk_w),
    .max_in   (cfg_l),
    .last_clk (),
    .last     (last_l),
    .first    (first_l)
  );

  // Address is the chunk index inside the block
  always_ff @(posedge aclk) begin
    if (en_config || last_clk_w) begin
      ram_addr <= '0;
    end else if (en_copy) begin
      ram_addr <= ram_addr + 1'b1;
    end
  end

  // One access per chunk: old edge out, new bottom edge in
  assign edge_bot = pk_m_data[`ROWS-1 -: EDGE_WORDS];
  assign ram_we   = en_copy && !last_l;
  assign ram_en   = en_copy && !(first_l && last_l);

  edge_ram u_edge_ram (
    .aclk (aclk),
    .en   (ram_en),
    .we   (ram_we),
    .addr (ram_addr),
    .din  (edge_bot),
    .dout (ram_dout)
  );

  // Register stage lines up with the RAM read
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      r_vld <= 1'b0;
    end else if (s_take) begin
      r_vld <= en_copy;
    end
  end

  always_ff @(posedge aclk) begin
    if (s_take) begin
      data_r    <= pk_m_data;
      r_last    <= pk_m_last;
      first_l_r <= first_l;
    end
  end

  // Block 0 has nothing above it
  assign edge_top = first_l_r ? '0 : ram_dout;

  always_ff @(posedge aclk) begin
    if (s_take) begin
      shift_reg <= {data_r, edge_top};
    end else if (m_beat) begin
      shift_reg <= shift_reg >> `X_BITS;
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      m_valid    <= 1'b0;
      chunk_last <= 1'b0;
    end else if (s_take) begin
      m_valid    <= r_vld;
      chunk_last <= r_vld && r_last;
    end
  end

  assign m_last = chunk_last && last_kh;

  // Window starts kh2 rows above the block
  always_comb begin
    for (int r = 0; r < `ROWS; r++) begin
      m_data[r] = shift_reg[r + EDGE_WORDS - int'(kh2_q)];
    end
  end

endmodule

/* sim/axis_pixels_tb.sv */
`timescale 1ns/1ps
`include "pixels_params.svh"

module axis_pixels_tb;

  localparam int EXT_WORDS   = `ROWS + 2 * `EDGE_WORDS;
  localparam int CHUNK_WORDS = `ROWS + `EDGE_WORDS;
  localparam int NUM_CASES   = 7;

  typedef struct {
    string name;
    int    kh2;
    int    ci;
    int    w;
    int    l;
    bit    ragged;
    int    stall_pct;
  } case_t;

  case_t cases [NUM_CASES] = '{
    '{"single_tap",    0, 1,  2, 0, 1'b0,  0},
    '{"three_taps",    1, 2,  1, 0, 1'b0,  0},
    '{"multi_block",   1, 1,  2, 2, 1'b0,  0},
    '{"ragged_keep",   1, 1,  2, 2, 1'b1,  0},
    '{"ragged_stall",  1, 2,  3, 1, 1'b1, 40},
    '{"tall_column",   0, 0,  0, 3, 1'b0, 25},
    '{"full_edge_ram", 1, 7, 15, 1, 1'b0, 30}
  };

  logic aclk;
  logic aresetn;
  logic s_ready;
  logic s_valid;
  logic s_last;
  pix_pkg::s_beat_t s_data;
  pix_pkg::s_keep_t s_keep;
  logic m_ready;
  logic m_valid;
  pix_pkg::block_t m_data;
  logic m_last;

  pix_pkg::word_t img [`XH_MAX][`XW_MAX][`CI_MAX];
  pix_pkg::word_t in_q [$];
  pix_pkg::block_t exp_q [$];
  logic exp_last_q [$];
  logic [31:0] pix_state = 32'd16683;
  logic [31:0] stall_state = 32'd16683;
  int stall_pct = 0;
  string cur_name = "reset";

  axis_pixels u_axis_pixels (
    .aclk    (aclk),
    .aresetn (aresetn),
    .s_ready (s_ready),
    .s_valid (s_valid),
    .s_last  (s_last),
    .s_data  (s_data),
    .s_keep  (s_keep),
    .m_ready (m_ready),
    .m_valid (m_valid),
    .m_data  (m_data),
    .m_last  (m_last)
  );

  initial begin
    aclk = 1'b0;
    forever #5 aclk = ~aclk;
  end

  function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic check_block(input string name, input pix_pkg::block_t exp,
                             input pix_pkg::block_t act);
    if (act !== exp) begin
      report_failure($sformatf("** Error %s: m_data expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_last(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      report_failure($sformatf("** Error %s: m_last expected %b, actual %b", name, exp, act));
    end
  endtask

  // Image, input word order and expected taps, all from the output rule
  task automatic build_case(input case_t tc);
    pix_pkg::word_t ext [EXT_WORDS];
    pix_pkg::block_t blk;
    int rows;
    int taps;
    int chunks;
    int chunk;
    int y;
    rows   = (tc.l + 1) * `ROWS;
    taps   = 2 * tc.kh2 + 1;
    chunks = (tc.ci + 1) * (tc.w + 1) * (tc.l + 1);
    chunk  = 0;
    // Same seed per case, so equal geometries carry equal pixels
    pix_state = 32'd16683;
    for (int yy = 0; yy < rows; yy++) begin
      for (int x = 0; x <= tc.w; x++) begin
        for (int c = 0; c <= tc.ci; c++) begin
          pix_state = lcg_step(pix_state);
          img[yy][x][c] = pix_state[23:16];
        end
      end
    end
    for (int b = 0; b <= tc.l; b++) begin
      for (int x = 0; x <= tc.w; x++) begin
        for (int c = 0; c <= tc.ci; c++) begin
          // Top edge, block rows, lookahead; zero outside the image
          for (int e = 0; e < EXT_WORDS; e++) begin
            y = b * `ROWS - `EDGE_WORDS + e;
            ext[e] = (y >= 0 && y < rows) ? img[y][x][c] : '0;
            if (e >= `EDGE_WORDS) begin
              in_q.push_back(ext[e]);
            end
          end
          for (int k = 0; k < taps; k++) begin
            for (int r = 0; r < `ROWS; r++) begin
              blk[r] = ext[r + k - tc.kh2 + `EDGE_WORDS];
            end
            exp_q.push_back(blk);
            exp_last_q.push_back((chunk == chunks - 1) && (k == taps - 1));
          end
          chunk++;
        end
      end
    end
  endtask

  task automatic send_beat(input pix_pkg::s_beat_t data, input pix_pkg::s_keep_t keep,
                           input logic last);
    s_valid <= 1'b1;
    s_data  <= data;
    s_keep  <= keep;
    s_last  <= last;
    @(negedge aclk);
    while (!s_ready) @(negedge aclk);
    @(posedge aclk);
  endtask

  task automatic send_image(input case_t tc);
    pix_pkg::s_beat_t beat;
    pix_pkg::s_keep_t keep;
    int n;
    beat = pix_pkg::s_beat_t'({cfg_pkg::l_t'(tc.l), cfg_pkg::w_t'(tc.w),
                               cfg_pkg::ci_t'(tc.ci), cfg_pkg::kh2_t'(tc.kh2)});
    send_beat(beat, '1, 1'b0);
    while (in_q.size() > 0) begin
      n = `S_WORDS;
      if (tc.ragged) begin
        pix_state = lcg_step(pix_state);
        n = 1 + int'(pix_state[17:16]);
      end
      if (n > in_q.size()) begin
        n = in_q.size();
      end
      // Unused lanes carry filler that must be ignored
      for (int j = 0; j < `S_WORDS; j++) begin
        if (j < n) begin
          beat[j] = in_q.pop_front();
        end else begin
          beat[j] = 8'ha5;
        end
      end
      keep = pix_pkg::s_keep_t'((1 << n) - 1);
      send_beat(beat, keep, in_q.size() == 0);
    end
    s_valid <= 1'b0;
    s_last  <= 1'b0;
  endtask

  initial begin
    aresetn = 1'b0;
    s_valid = 1'b0;
    s_last  = 1'b0;
    s_data  = '0;
    s_keep  = '0;
    repeat (10) @(posedge aclk);
    if (m_valid !== 1'b0) begin
      report_failure("m_valid is not low during reset");
    end
    aresetn <= 1'b1;
    foreach (cases[i]) begin
      cur_name    = cases[i].name;
      stall_pct   = cases[i].stall_pct;
      build_case(cases[i]);
      send_image(cases[i]);
      while (exp_q.size() != 0) @(posedge aclk);
    end
    repeat (20) @(posedge aclk);
    $display("** PASS **");
    $finish;
  end

  // Random back-pressure on the output
  initial begin
    m_ready = 1'b0;
    forever begin
      @(posedge aclk);
      stall_state = lcg_step(stall_state);
      m_ready <= (int'(stall_state[30:16]) % 100) >= stall_pct;
    end
  end

  // Beat transfers on the next rising edge
  initial begin
    pix_pkg::block_t exp_blk;
    logic exp_last;
    forever begin
      @(negedge aclk);
      if (aresetn && m_valid && m_ready) begin
        if (exp_q.size() == 0) begin
          report_failure("An output beat arrived when no beat was expected");
        end else begin
          exp_blk  = exp_q.pop_front();
          exp_last = exp_last_q.pop_front();
          check_block(cur_name, exp_blk, m_data);
          check_last(cur_name, exp_last, m_last);
        end
      end
    end
  end

  initial begin
    int limit;
    int chunks;
    limit = 200;
    // A cycle per word and per tap, four times over for stalls
    foreach (cases[i]) begin
      chunks = (cases[i].ci + 1) * (cases[i].w + 1) * (cases[i].l + 1);
      limit += 4 * (chunks * (CHUNK_WORDS + 2 * cases[i].kh2 + 1) + 50);
    end
    repeat (limit) @(posedge aclk);
    report_failure("Timeout: the expected output beats did not all arrive in time");
  end

endmodule

/* verilog.f */
+incdir+include
rtl/pix_pkg.sv
rtl/cfg_pkg.sv
rtl/loop_counter.sv
rtl/edge_ram.sv
rtl/pixel_word_packer.sv
rtl/axis_pixels.sv
sim/axis_pixels_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the axis_pixels testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing -f verilog.f --top-module axis_pixels_tb > build.log 2>&1 \
  || { cat build.log; echo "Result: build error"; exit 1; }

./obj_dir/Vaxis_pixels_tb > sim.log 2>&1
cat sim.log

grep -q '\*\* FAIL \*\*' sim.log && { echo "Result: failed"; exit 1; }
grep -q '\*\* PASS \*\*' sim.log || { echo "Result: run ended without a result"; exit 1; }
echo "Result: passed"
